// File: include/power_ctrl_defines.svh
`ifndef POWER_CTRL_DEFINES_SVH
`define POWER_CTRL_DEFINES_SVH

// Stable cycles before a filtered pin follows its input
`define PC_FILTER_LEN 4

// Dead time between bridge pause and new pattern
`define PC_WAITSTATES 6

// Length of one soft-start step and of the start hold
`define PC_STEP_CYCLES 40

`define PC_PWM_WIDTH 4 // Period is 2**width

`endif

// File: logic/power_ctrl_pkg.sv
`include "power_ctrl_defines.svh"

package power_ctrl_pkg;

  typedef logic [2:0] cmd_code_t;
  typedef logic [`PC_PWM_WIDTH-1:0] pwm_level_t;
  typedef logic [$clog2(`PC_STEP_CYCLES + 1)-1:0] step_timer_t;
  typedef logic [$clog2(`PC_WAITSTATES + 1)-1:0] ws_count_t;
  typedef logic [3:0] ramp_idx_t;

  // All zero is the paused bridge
  typedef struct packed {
    logic [3:0] top;     // Leg 1 on bit 0
    logic [3:0] bot;
    logic       plus;
    logic       minus;
    logic       pause_p;
    logic       pause_n;
  } bridge_t;

  typedef struct packed {
    logic [3:0] err_dr;
    logic       err_u;
    logic       err_i;
    logic       bt;
    logic       stop_k;
  } fault_in_t;

  typedef struct packed {
    logic       stop;
    logic       avv;
    logic       avi;
    logic       td;
    logic [3:0] erbd;
  } fault_flags_t;

  typedef enum logic [2:0] {
    CS_IDLE,
    CS_START_ARM,
    CS_DIS0,
    CS_DIS1,
    CS_DIS2
  } cmd_state_e;

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_STEP,
    RS_HOLD
  } ramp_state_e;

endpackage

// File: logic/input_deglitch.sv
`include "power_ctrl_defines.svh"

module input_deglitch #(
  parameter int N = 1
) (
  input  logic         lclk,
  input  logic         rstn,
  input  logic [N-1:0] i_raw,
  output logic [N-1:0] o_clean
);

  localparam int CW = $clog2(`PC_FILTER_LEN + 1);

  logic [CW-1:0] r_cnt [N]; // Cycles the pin has differed from o_clean

  always_ff @(posedge lclk or negedge rstn) begin
    if (!rstn) begin
      for (int b = 0; b < N; b++) begin
        r_cnt[b] <= '0;
      end
      o_clean <= '0;
    end else begin
      for (int b = 0; b < N; b++) begin
        if (i_raw[b] == o_clean[b]) begin
          r_cnt[b] <= '0;                          // Glitch ended, start over
        end else if (r_cnt[b] == CW'(`PC_FILTER_LEN - 1)) begin
          r_cnt[b]   <= '0;
          o_clean[b] <= i_raw[b];
        end else begin
          r_cnt[b] <= r_cnt[b] + 1'b1;
        end
      end
    end
  end

endmodule

// File: logic/command_decoder.sv
`include "power_ctrl_defines.svh"

module command_decoder (
  input  logic                      lclk,
  input  logic                      rstn,
  input  logic                      i_strobe,
  input  power_ctrl_pkg::cmd_code_t i_cmd,
  input  logic                      i_ramp_busy,
  input  logic                      i_ramp_done,
  input  logic                      i_fault_latched,
  output power_ctrl_pkg::bridge_t   o_bridge,
  output logic                      o_start_req,
  output logic                      o_abort_req
);

  import power_ctrl_pkg::*;

  localparam ws_count_t WS_LOAD = ws_count_t'(`PC_WAITSTATES);

  logic       r_strobe_d;
  cmd_state_e r_state;
  logic       r_ready;
  logic       r_pending; // Pattern staged, waiting for dead time
  ws_count_t  r_ws;
  bridge_t    r_next;
  logic       w_fall;
  logic       w_accept;

  function automatic bridge_t pattern_for(input cmd_code_t code);
    bridge_t b;
    b = '0;
    case (code)
      3'd1: begin
        b.top  = 4'b0001;
        b.bot  = 4'b0010;
        b.plus = 1'b1;
      end
      3'd2: begin
        b.top   = 4'b0010;
        b.bot   = 4'b0001;
        b.minus = 1'b1;
      end
      3'd3: begin
        b.top     = 4'b0100;
        b.bot     = 4'b1000;
        b.pause_p = 1'b1;
      end
      3'd4: begin
        b.top     = 4'b1000;
        b.bot     = 4'b0100;
        b.pause_n = 1'b1;
      end
      default: b = '0;
    endcase
    return b;
  endfunction

  // Valid strobe edge, dropped while a change is still pending
  assign w_fall   = r_strobe_d & ~i_strobe & ~r_pending & ~i_fault_latched;
  assign w_accept = w_fall && (r_state == CS_IDLE) && (i_cmd inside {3'd1, 3'd2, 3'd3, 3'd4})
                    && r_ready && !i_ramp_busy;

  always_ff @(posedge lclk) begin
    if (w_accept) begin
      r_next <= pattern_for(i_cmd);
    end
  end

  always_ff @(posedge lclk or negedge rstn) begin
    if (!rstn) begin
      r_strobe_d  <= 1'b0;
      r_state     <= CS_IDLE;
      r_ready     <= 1'b0;
      r_pending   <= 1'b0;
      r_ws        <= '0;
      o_bridge    <= '0;
      o_start_req <= 1'b0;
      o_abort_req <= 1'b0;
    end else begin
      r_strobe_d  <= i_strobe;
      o_start_req <= 1'b0;
      o_abort_req <= 1'b0;
      if (i_fault_latched) begin
        r_state   <= CS_IDLE;                   // Locked out until reset
        r_ready   <= 1'b0;
        r_pending <= 1'b0;
        r_ws      <= '0;
        o_bridge  <= '0;
      end else begin
        if (i_ramp_done) begin
          r_ready <= 1'b1;
        end
        if (r_ws != '0) begin
          r_ws <= r_ws - 1'b1;
        end else if (r_pending) begin
          r_pending <= 1'b0;
          o_bridge  <= r_next;
        end
        if (w_accept) begin
          o_bridge  <= '0;
          r_ws      <= WS_LOAD;
          r_pending <= 1'b1;
        end else if (w_fall) begin
          r_state <= CS_IDLE;
          case (r_state)
            CS_IDLE: begin
              case (i_cmd)
                3'd0: o_bridge <= '0;
                3'd5: r_state <= i_ramp_busy ? CS_IDLE : CS_START_ARM;
                3'd6: begin
                  o_abort_req <= 1'b1;
                  r_ready     <= 1'b0;
                  o_bridge    <= '0;
                end
                3'd7: r_state <= i_ramp_busy ? CS_IDLE : CS_DIS0;
                default: r_state <= CS_IDLE;       // Refused bridge command
              endcase
            end
            CS_START_ARM: begin
              if (i_cmd == 3'd0 && !i_ramp_busy) begin
                o_start_req <= 1'b1;
                o_bridge    <= '0;
              end
            end
            CS_DIS0: if (i_cmd == 3'd0) r_state <= CS_DIS1;
            CS_DIS1: if (i_cmd == 3'd7) r_state <= CS_DIS2;
            CS_DIS2: if (i_cmd == 3'd0) r_ready <= 1'b1; // Unlock done
            default: r_state <= CS_IDLE;
          endcase
        end
      end
    end
  end

endmodule

// File: logic/soft_start_sequencer.sv
`include "power_ctrl_defines.svh"

module soft_start_sequencer (
  input  logic lclk,
  input  logic rstn,
  input  logic i_start_req,
  input  logic i_abort_req,
  input  logic i_fault_latched,
  output logic o_ramp_busy,
  output logic o_ramp_done,
  output logic o_charge,
  output logic o_charge_pwm,
  output logic o_st,
  output logic o_fan
);

  import power_ctrl_pkg::*;

  localparam step_timer_t STEP_LOAD = step_timer_t'(`PC_STEP_CYCLES - 1);
  localparam pwm_level_t  QUARTER   = pwm_level_t'(1 << (`PC_PWM_WIDTH - 2));
  localparam pwm_level_t  HALF      = pwm_level_t'(1 << (`PC_PWM_WIDTH - 1));

  ramp_state_e r_state;
  step_timer_t r_timer;
  ramp_idx_t   r_step;
  pwm_level_t  r_cnt;
  pwm_level_t  r_duty;

  function automatic pwm_level_t duty_for(input ramp_idx_t idx);
    pwm_level_t duty;
    if (idx <= 4'd4) begin
      duty = QUARTER;
    end else if (idx <= 4'd8) begin
      duty = HALF;
    end else if (idx <= 4'd11) begin
      duty = HALF + QUARTER;
    end else begin
      duty = '1;                                   // Fully on
    end
    return duty;
  endfunction

  assign o_ramp_busy  = (r_state != RS_IDLE);
  assign o_charge_pwm = o_charge & ((r_cnt < r_duty) | (&r_duty));

  always_ff @(posedge lclk or negedge rstn) begin
    if (!rstn) begin
      r_cnt <= '0;
    end else begin
      r_cnt <= r_cnt + 1'b1;                       // Free running
    end
  end

  always_ff @(posedge lclk or negedge rstn) begin
    if (!rstn) begin
      r_state     <= RS_IDLE;
      r_timer     <= '0;
      r_step      <= '0;
      r_duty      <= '0;
      o_ramp_done <= 1'b0;
      o_charge    <= 1'b0;
      o_st        <= 1'b0;
      o_fan       <= 1'b0;
    end else if (i_fault_latched || i_abort_req) begin
      r_state     <= RS_IDLE;
      r_timer     <= '0;
      r_step      <= '0;
      r_duty      <= '0;
      o_ramp_done <= 1'b0;
      o_charge    <= 1'b0;
      o_st        <= 1'b0;
      o_fan       <= 1'b0;
    end else begin
      o_ramp_done <= 1'b0;
      case (r_state)
        RS_IDLE: begin
          if (i_start_req) begin
            o_fan    <= 1'b1;
            o_charge <= 1'b1;
            o_st     <= 1'b0;
            r_step   <= 4'd1;
            r_duty   <= duty_for(4'd1);
            r_timer  <= STEP_LOAD;
            r_state  <= RS_STEP;
          end
        end
        RS_STEP: begin
          if (r_timer != '0) begin
            r_timer <= r_timer - 1'b1;
          end else if (r_step == 4'd15) begin
            o_st    <= 1'b1;
            r_timer <= STEP_LOAD;
            r_state <= RS_HOLD;
          end else begin
            r_step  <= r_step + 1'b1;
            r_duty  <= duty_for(r_step + 1'b1);
            r_timer <= STEP_LOAD;
          end
        end
        RS_HOLD: begin
          if (r_timer != '0) begin
            r_timer <= r_timer - 1'b1;
          end else begin
            o_charge    <= 1'b0;                   // Start hold over
            r_duty      <= '0;
            r_step      <= '0;
            o_ramp_done <= 1'b1;
            r_state     <= RS_IDLE;
          end
        end
        default: r_state <= RS_IDLE;
      endcase
    end
  end

endmodule

// File: logic/fault_supervisor.sv
module fault_supervisor (
  input  logic                         lclk,
  input  logic                         rstn,
  input  power_ctrl_pkg::fault_in_t    i_faults,
  input  logic                         i_fan,
  output logic                         o_fault_latched,
  output logic                         o_fan,
  output logic                         o_break,
  output power_ctrl_pkg::fault_flags_t o_flags
);

  import power_ctrl_pkg::*;

  logic         w_any_fault;
  fault_flags_t w_flags_set; // Sources active this cycle

  assign w_any_fault = |i_faults;

  always_comb begin
    w_flags_set.stop = i_faults.stop_k;
    w_flags_set.avv  = i_faults.err_u;
    w_flags_set.avi  = i_faults.err_i;
    w_flags_set.td   = i_faults.bt;
    w_flags_set.erbd = i_faults.err_dr;
  end

  // First fault wins, cleared only by reset
  always_ff @(posedge lclk or negedge rstn) begin
    if (!rstn) begin
      o_fault_latched <= 1'b0;
      o_flags         <= '0;
    end else begin
      if (w_any_fault) begin
        o_fault_latched <= 1'b1;
      end
      o_flags <= o_flags | w_flags_set;        // Sticky per source
    end
  end

  assign o_break = o_fault_latched;
  assign o_fan   = i_fan | o_fault_latched;    // Keep cooling after a fault

endmodule

// File: logic/power_ctrl_top.sv
`include "power_ctrl_defines.svh"

module power_ctrl_top (
  input  logic                         lclk,
  input  logic                         rstn,
  input  logic                         i_strobe_n,
  input  logic [2:0]                   i_cmd_n,
  input  logic [3:0]                   i_err_dr_n,
  input  logic                         i_err_u_n,
  input  logic                         i_err_i_n,
  input  logic                         i_stop_k_n,
  input  logic                         i_bt,
  output power_ctrl_pkg::bridge_t      o_bridge,
  output logic                         o_charge,
  output logic                         o_charge_pwm,
  output logic                         o_st,
  output logic                         o_fan,
  output logic                         o_break,
  output power_ctrl_pkg::fault_flags_t o_flags
);

  import power_ctrl_pkg::*;

  logic      w_strobe;
  cmd_code_t w_cmd;
  fault_in_t w_faults;
  logic      w_start_req;
  logic      w_abort_req;
  logic      w_ramp_busy;
  logic      w_ramp_done;
  logic      w_fault_latched;
  logic      w_seq_fan;

  input_deglitch #(.N(4)) u_cmd_filt (
    .lclk    (lclk),
    .rstn    (rstn),
    .i_raw   ({~i_strobe_n, ~i_cmd_n}),
    .o_clean ({w_strobe, w_cmd})
  );

  // Order matches fault_in_t, bt is already active high
  input_deglitch #(.N($bits(fault_in_t))) u_fault_filt (
    .lclk    (lclk),
    .rstn    (rstn),
    .i_raw   ({~i_err_dr_n, ~i_err_u_n, ~i_err_i_n, i_bt, ~i_stop_k_n}),
    .o_clean (w_faults)
  );

  command_decoder u_decoder (
    .lclk            (lclk),
    .rstn            (rstn),
    .i_strobe        (w_strobe),
    .i_cmd           (w_cmd),
    .i_ramp_busy     (w_ramp_busy),
    .i_ramp_done     (w_ramp_done),
    .i_fault_latched (w_fault_latched),
    .o_bridge        (o_bridge),
    .o_start_req     (w_start_req),
    .o_abort_req     (w_abort_req)
  );

  soft_start_sequencer u_sequencer (
    .lclk            (lclk),
    .rstn            (rstn),
    .i_start_req     (w_start_req),
    .i_abort_req     (w_abort_req),
    .i_fault_latched (w_fault_latched),
    .o_ramp_busy     (w_ramp_busy),
    .o_ramp_done     (w_ramp_done),
    .o_charge        (o_charge),
    .o_charge_pwm    (o_charge_pwm),
    .o_st            (o_st),
    .o_fan           (w_seq_fan)
  );

  fault_supervisor u_supervisor (
    .lclk            (lclk),
    .rstn            (rstn),
    .i_faults        (w_faults),
    .i_fan           (w_seq_fan),
    .o_fault_latched (w_fault_latched),
    .o_fan           (o_fan),
    .o_break         (o_break),
    .o_flags         (o_flags)
  );

endmodule

// File: verification/power_ctrl_asserts.sv
`include "power_ctrl_defines.svh"

module power_ctrl_asserts (
  input  logic                         lclk,
  input  logic                         rstn,
  input  power_ctrl_pkg::bridge_t      i_bridge,
  input  logic                         i_charge,
  input  logic                         i_charge_pwm,
  input  logic                         i_st,
  input  logic                         i_fan,
  input  logic                         i_break,
  input  logic                         i_fault_latched,
  input  power_ctrl_pkg::fault_flags_t i_flags
);

  import power_ctrl_pkg::*;

  localparam int ST_MIN = 15 * `PC_STEP_CYCLES;

  int                              fail_count = 0; // Polled by the testbench
  logic [7:0]                      r_zero_run;     // Consecutive paused cycles
  logic [11:0]                     r_charge_run;   // Consecutive charge cycles
  logic                            w_bridge_on;
  logic [$bits(fault_flags_t)-1:0] w_flag_bits;

  assign w_bridge_on = (i_bridge != '0);
  assign w_flag_bits = i_flags;

  always_ff @(posedge lclk or negedge rstn) begin
    if (!rstn) begin
      r_zero_run   <= '0;
      r_charge_run <= '0;
    end else begin
      if (w_bridge_on) begin
        r_zero_run <= '0;
      end else if (r_zero_run != 8'hff) begin
        r_zero_run <= r_zero_run + 1'b1;
      end
      if (!i_charge) begin
        r_charge_run <= '0;
      end else if (r_charge_run != 12'hfff) begin
        r_charge_run <= r_charge_run + 1'b1;
      end
    end
  end

  a_dead_time: assert property (@(posedge lclk) disable iff (!rstn)
    $rose(w_bridge_on) |-> (r_zero_run >= `PC_WAITSTATES))
  else begin
    $error("Bridge pattern applied after %0d paused cycles", r_zero_run);
    fail_count++;
  end

  a_leg_overlap: assert property (@(posedge lclk) disable iff (!rstn)
    (i_bridge.top & i_bridge.bot) == 4'b0000)
  else begin
    $error("Top and bot driven together on leg mask %b", i_bridge.top & i_bridge.bot);
    fail_count++;
  end

  // PWM only with charge, fully on through the start hold
  a_pwm_gated: assert property (@(posedge lclk) disable iff (!rstn)
    (i_charge || !i_charge_pwm) && (!(i_st && i_charge) || i_charge_pwm))
  else begin
    $error("Charge PWM %0b with charge %0b and st %0b", i_charge_pwm, i_charge, i_st);
    fail_count++;
  end

  // Start only after the full fifteen step ramp
  a_st_late: assert property (@(posedge lclk) disable iff (!rstn)
    $rose(i_st) |-> (i_charge && (r_charge_run >= ST_MIN)))
  else begin
    $error("st raised after %0d charge cycles", r_charge_run);
    fail_count++;
  end

  a_fault_hold: assert property (@(posedge lclk) disable iff (!rstn)
    i_fault_latched |=> (i_fault_latched && i_break && i_fan && (i_bridge == '0)))
  else begin
    $error("Outputs released after a latched fault");
    fail_count++;
  end

  a_flags_sticky: assert property (@(posedge lclk) disable iff (!rstn)
    (~w_flag_bits & $past(w_flag_bits)) == '0)
  else begin
    $error("Fault indicator cleared without reset");
    fail_count++;
  end

endmodule

bind power_ctrl_top power_ctrl_asserts u_asserts (
  .lclk            (lclk),
  .rstn            (rstn),
  .i_bridge        (o_bridge),
  .i_charge        (o_charge),
  .i_charge_pwm    (o_charge_pwm),
  .i_st            (o_st),
  .i_fan           (o_fan),
  .i_break         (o_break),
  .i_fault_latched (w_fault_latched),
  .i_flags         (o_flags)
);

// File: verification/power_ctrl_tb.sv
`include "power_ctrl_defines.svh"

module power_ctrl_tb;

  import power_ctrl_pkg::*;

  localparam int HOLD       = 3 * `PC_FILTER_LEN;
  localparam int WAIT_LIMIT = HOLD + `PC_WAITSTATES + 10;
  localparam int RAMP_LEN   = 16 * `PC_STEP_CYCLES;
  localparam int TIMEOUT    = 4000;                        // Ramp plus 40 commands, with margin
  localparam int SEL_CHARGE = 0;
  localparam int SEL_ST     = 1;
  localparam int SEL_FAN    = 2;
  localparam int SEL_BREAK  = 3;

  logic         lclk = 1'b0;
  logic         rstn;
  logic         strobe_n;
  logic [2:0]   cmd_n;
  logic [3:0]   err_dr_n;
  logic         err_u_n;
  logic         err_i_n;
  logic         stop_k_n;
  logic         bt;
  bridge_t      bridge;
  logic         charge;
  logic         charge_pwm;
  logic         st;
  logic         fan;
  logic         brk;
  fault_flags_t flags;
  int           cycle_count = 0;
  int           charge_rise_cycle = 0;
  logic         charge_d = 1'b0;

  always #2 lclk = ~lclk;

  power_ctrl_top i_dut (
    .lclk         (lclk),
    .rstn         (rstn),
    .i_strobe_n   (strobe_n),
    .i_cmd_n      (cmd_n),
    .i_err_dr_n   (err_dr_n),
    .i_err_u_n    (err_u_n),
    .i_err_i_n    (err_i_n),
    .i_stop_k_n   (stop_k_n),
    .i_bt         (bt),
    .o_bridge     (bridge),
    .o_charge     (charge),
    .o_charge_pwm (charge_pwm),
    .o_st         (st),
    .o_fan        (fan),
    .o_break      (brk),
    .o_flags      (flags)
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what);
    stop_with_failure($sformatf("FAIL at time %0t: %s", $time, what));
  endtask

  always @(posedge lclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT) begin
      stop_with_failure($sformatf("Timeout: run did not finish in %0d cycles", TIMEOUT));
    end
  end

  always @(negedge lclk) begin
    charge_d <= charge;
    if (charge && !charge_d) begin
      charge_rise_cycle <= cycle_count;
    end
    if (i_dut.u_asserts.fail_count != 0) begin
      stop_with_failure("A bound safety assertion failed, see the error above");
    end
  end

  function automatic int rand_gap();
    return $urandom_range(6, 0);
  endfunction

  function automatic int rand_bridge_code();
    return $urandom_range(4, 1);
  endfunction

  // Plus and minus use legs 1 and 2, ballast uses legs 3 and 4
  function automatic bridge_t table_pattern(input int code);
    bridge_t b;
    int      top_leg;
    int      bot_leg;
    b       = '0;
    top_leg = code;
    bot_leg = (code % 2 == 1) ? code + 1 : code - 1;
    b.top[top_leg-1] = 1'b1;
    b.bot[bot_leg-1] = 1'b1;
    b.plus    = (code == 1);
    b.minus   = (code == 2);
    b.pause_p = (code == 3);
    b.pause_n = (code == 4);
    return b;
  endfunction

  // Pins 0 to 3 are err_dr, then err_u, err_i, stop_k, bt
  function automatic fault_flags_t flag_for_pin(input int pin);
    fault_flags_t f;
    f = '0;
    if (pin < 4) f.erbd[pin] = 1'b1;
    else if (pin == 4) f.avv = 1'b1;
    else if (pin == 5) f.avi = 1'b1;
    else if (pin == 6) f.stop = 1'b1;
    else f.td = 1'b1;
    return f;
  endfunction

  // High cycles per PWM period: quarter, half, three quarters, then always on
  function automatic int pwm_high_cycles(input int step);
    int period;
    period = 1 << `PC_PWM_WIDTH;
    if (step <= 4) return period / 4;
    else if (step <= 8) return period / 2;
    else if (step <= 11) return period * 3 / 4;
    return period;
  endfunction

  function automatic logic probe(input int sel);
    case (sel)
      SEL_CHARGE: return charge;
      SEL_ST:     return st;
      SEL_FAN:    return fan;
      default:    return brk;
    endcase
  endfunction

  task automatic send_cmd(input cmd_code_t code, input int gap);
    repeat (gap) begin
      @(posedge lclk);
      cmd_n <= 3'($urandom);                      // Bus noise, strobe idle
    end
    @(posedge lclk);
    cmd_n <= ~code;
    repeat (HOLD) @(posedge lclk);
    strobe_n <= 1'b0;
    repeat (HOLD) @(posedge lclk);
    strobe_n <= 1'b1;                             // Decoder acts on this edge
    repeat (HOLD) @(posedge lclk);
  endtask

  task automatic unlock();
    send_cmd(3'd7, rand_gap());
    send_cmd(3'd0, rand_gap());
    send_cmd(3'd7, rand_gap());
    send_cmd(3'd0, rand_gap());
  endtask

  task automatic wait_bridge(input bridge_t expected);
    int n;
    n = 0;
    @(negedge lclk);
    while (bridge != expected && n < WAIT_LIMIT) begin
      @(negedge lclk);
      n++;
    end
    assert (bridge == expected)
      else report_mismatch($sformatf("bridge %h, expected %h", bridge, expected));
  endtask

  task automatic watch_bridge_zero(input int cycles, input string what);
    repeat (cycles) begin
      @(negedge lclk);
      assert (bridge == '0) else report_mismatch(what);
    end
  endtask

  task automatic wait_for_level(input int sel, input logic level, input int limit,
                                input string what);
    int n;
    n = 0;
    @(negedge lclk);
    while (probe(sel) !== level && n < limit) begin
      @(negedge lclk);
      n++;
    end
    assert (probe(sel) === level)
      else report_mismatch($sformatf("%s did not reach %0b", what, level));
  endtask

  // Counts PWM high cycles over one period well inside the given step
  task automatic check_step_duty(input int step);
    int period;
    int high;
    period = 1 << `PC_PWM_WIDTH;
    high   = 0;
    while (cycle_count < charge_rise_cycle + (step - 1) * `PC_STEP_CYCLES + 8) begin
      @(negedge lclk);
    end
    repeat (period) begin
      @(negedge lclk);
      if (charge_pwm) high++;
    end
    assert (high == pwm_high_cycles(step))
      else report_mismatch($sformatf("step %0d PWM high for %0d of %0d cycles",
                                     step, high, period));
  endtask

  task automatic pull_fault(input int pin);
    @(posedge lclk);
    if (pin < 4) err_dr_n <= err_dr_n & ~(4'b0001 << pin);
    else if (pin == 4) err_u_n <= 1'b0;
    else if (pin == 5) err_i_n <= 1'b0;
    else if (pin == 6) stop_k_n <= 1'b0;
    else bt <= 1'b1;                              // Only active-high pin
  endtask

  initial begin
    int code;
    int pin;
    int step;
    strobe_n = 1'b1;
    cmd_n    = 3'b111;
    err_dr_n = 4'hf;
    err_u_n  = 1'b1;
    err_i_n  = 1'b1;
    stop_k_n = 1'b1;
    bt       = 1'b0;
    rstn     = 1'b0;
    void'($urandom(54));
    repeat (5) @(posedge lclk);
    rstn <= 1'b1;
    @(negedge lclk);
    assert (bridge == '0 && !charge && !st && !fan && !brk && flags == '0)
      else report_mismatch("outputs not low after reset");

    repeat (2) begin                              // Locked until unlock
      send_cmd(cmd_code_t'(rand_bridge_code()), rand_gap());
      watch_bridge_zero(HOLD, "bridge command accepted while locked");
    end
    unlock();
    for (code = 1; code <= 4; code++) begin
      send_cmd(cmd_code_t'(code), rand_gap());
      wait_bridge(table_pattern(code));
      send_cmd(3'd0, rand_gap());
      wait_bridge('0);
    end

    // Soft start
    send_cmd(3'd5, rand_gap());
    send_cmd(3'd0, rand_gap());
    wait_for_level(SEL_CHARGE, 1'b1, WAIT_LIMIT, "charge");
    assert (fan) else report_mismatch("fan not raised with charge");
    send_cmd(cmd_code_t'(rand_bridge_code()), rand_gap());
    watch_bridge_zero(HOLD, "bridge command accepted during ramp");
    for (step = 3; step <= 15; step++) begin    // Steps 1 and 2 pass during the refused command
      check_step_duty(step);
    end
    wait_for_level(SEL_ST, 1'b1, RAMP_LEN, "st");
    assert (cycle_count - charge_rise_cycle >= 15 * `PC_STEP_CYCLES)
      else report_mismatch("st raised before the ramp finished");
    wait_for_level(SEL_CHARGE, 1'b0, `PC_STEP_CYCLES + 4, "charge");
    code = rand_bridge_code();
    send_cmd(cmd_code_t'(code), rand_gap());
    wait_bridge(table_pattern(code));

    // Shutdown from a driven bridge, then during the start hold
    send_cmd(3'd6, rand_gap());
    wait_bridge('0);
    send_cmd(cmd_code_t'(rand_bridge_code()), rand_gap());
    watch_bridge_zero(HOLD, "bridge command accepted after shutdown");
    send_cmd(3'd5, rand_gap());
    send_cmd(3'd0, rand_gap());
    wait_for_level(SEL_ST, 1'b1, RAMP_LEN, "st");
    send_cmd(3'd6, 0);
    wait_for_level(SEL_ST, 1'b0, WAIT_LIMIT, "st");
    wait_for_level(SEL_CHARGE, 1'b0, WAIT_LIMIT, "charge");
    wait_for_level(SEL_FAN, 1'b0, WAIT_LIMIT, "fan");
    assert (bridge == '0) else report_mismatch("bridge driven after shutdown");

    unlock();
    code = rand_bridge_code();
    send_cmd(cmd_code_t'(code), rand_gap());
    wait_bridge(table_pattern(code));

    // Fault lockout
    pin = $urandom_range(7, 0);
    pull_fault(pin);
    wait_for_level(SEL_BREAK, 1'b1, WAIT_LIMIT, "break");
    @(negedge lclk);
    assert (fan && bridge == '0 && flags == flag_for_pin(pin))
      else report_mismatch($sformatf("outputs after fault on pin %0d", pin));
    send_cmd(cmd_code_t'(rand_bridge_code()), rand_gap());
    send_cmd(3'd5, rand_gap());
    send_cmd(3'd0, rand_gap());
    repeat (HOLD) begin
      @(negedge lclk);
      assert (brk && fan && bridge == '0 && !charge && flags == flag_for_pin(pin))
        else report_mismatch("command acted after a latched fault");
    end

    if (i_dut.u_asserts.fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      stop_with_failure("Bound assertions reported errors");
    end
  end

endmodule

// File: power_ctrl.f
+incdir+include
logic/power_ctrl_pkg.sv
logic/input_deglitch.sv
logic/command_decoder.sv
logic/soft_start_sequencer.sv
logic/fault_supervisor.sv
logic/power_ctrl_top.sv
verification/power_ctrl_asserts.sv
verification/power_ctrl_tb.sv

// File: Bender.yml
package:
  name: power_ctrl

sources:
  - include_dirs:
      - include
    files:
      - logic/power_ctrl_pkg.sv
      - logic/input_deglitch.sv
      - logic/command_decoder.sv
      - logic/soft_start_sequencer.sv
      - logic/fault_supervisor.sv
      - logic/power_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/power_ctrl_asserts.sv
      - verification/power_ctrl_tb.sv
